// ==== src/mover_pkg.sv ====
// Shared sizes, register map constants, stream payload types and the
// sequencer state type for the data mover
package mover_pkg;

    // Number of programmable channels and the width of a channel index
    localparam int MAX_CHANNELS = 8;
    localparam int CHANNEL_BITS = 3;

    // One bit wider than a channel index so a count of 8 fits
    localparam int COUNT_BITS = 4;

    // Source and target addresses are both 16 bits wide
    localparam int ADDR_BITS = 16;

    // Width of data words and of the Wishbone data buses
    localparam int DATA_BITS = 32;

    // Wishbone word address width, enough for the count plus eight channels
    localparam int WB_ADDR_BITS = 4;

    // Word 0 holds the channel count, channel n lives at word n+1
    localparam int REG_COUNT_INDEX = 0;

    // Payload of the request stream, just the source address
    typedef logic [ADDR_BITS-1:0] request_t;

    // Payload of the output stream, a fetched word and where it goes
    typedef struct packed {
        logic [DATA_BITS-1:0] data;
        logic [ADDR_BITS-1:0] dest;
    } output_t;

    // States of the channel sequencer FSM
    typedef enum logic [2:0] {
        idle          = 3'd0,
        issue_request = 3'd1,
        wait_response = 3'd2,
        replay_word   = 3'd3,
        done_pulse    = 3'd4
    } sequencer_state_t;

endpackage

// ==== src/wb_register_bank.sv ====
// Wishbone classic slave with the channel count register and the
// per-channel source and target address registers
`timescale 1ns/10ps

module wb_register_bank import mover_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [WB_ADDR_BITS-1:0] wb_adr,
    input  logic [DATA_BITS-1:0]    wb_dat_w,
    output logic [DATA_BITS-1:0]    wb_dat_r,
    output logic                    wb_ack,
    output logic [COUNT_BITS-1:0]   channel_count,
    output logic [ADDR_BITS-1:0]    source_addrs [MAX_CHANNELS],
    output logic [ADDR_BITS-1:0]    target_addrs [MAX_CHANNELS]
);

    logic                    strobe_seen;
    logic                    count_hit;
    logic                    channel_hit;
    logic [CHANNEL_BITS-1:0] channel_sel;
    logic [COUNT_BITS-1:0]   count_write;
    logic [DATA_BITS-1:0]    read_word;

    // A new cycle is one where the host strobes and no ack is pending yet
    assign strobe_seen = wb_cyc && wb_stb && !wb_ack;

    // Address decode for the count word and the channel words
    assign count_hit   = (wb_adr == WB_ADDR_BITS'(REG_COUNT_INDEX));
    assign channel_hit = (wb_adr > WB_ADDR_BITS'(REG_COUNT_INDEX)) &&
                         (wb_adr <= WB_ADDR_BITS'(REG_COUNT_INDEX + MAX_CHANNELS));
    assign channel_sel = CHANNEL_BITS'(wb_adr - WB_ADDR_BITS'(REG_COUNT_INDEX + 1));

    // Counts above the number of channels are clamped to the maximum
    // The whole word is compared so large values cannot wrap to small ones
    assign count_write = (wb_dat_w > DATA_BITS'(MAX_CHANNELS)) ?
                         COUNT_BITS'(MAX_CHANNELS) : wb_dat_w[COUNT_BITS-1:0];

    // Read-back mux, unmapped words return zero
    always_comb begin
        read_word = '0;
        if (count_hit) begin
            read_word = DATA_BITS'(channel_count);
        end else if (channel_hit) begin
            read_word = {target_addrs[channel_sel], source_addrs[channel_sel]};
        end
    end

    // Control and configuration registers, acked one cycle after the strobe
    always_ff @(posedge clock) begin
        if (!reset) begin
            wb_ack        <= 1'b0;
            channel_count <= '0;
            for (int i = 0; i < MAX_CHANNELS; i++) begin
                source_addrs[i] <= '0;
                target_addrs[i] <= '0;
            end
        end else begin
            wb_ack <= strobe_seen;
            // The write lands on the same edge that raises ack
            if (strobe_seen && wb_we) begin
                if (count_hit) begin
                    channel_count <= count_write;
                end else if (channel_hit) begin
                    target_addrs[channel_sel] <= wb_dat_w[DATA_BITS-1:ADDR_BITS];
                    source_addrs[channel_sel] <= wb_dat_w[ADDR_BITS-1:0];
                end
            end
        end
    end

    // Read data is captured with the ack and held while ack is high
    always_ff @(posedge clock) begin
        if (strobe_seen) begin
            wb_dat_r <= read_word;
        end
    end

endmodule

// ==== src/stream_stage.sv ====
// Two-entry valid/ready register stage for an arbitrary payload type
`timescale 1ns/10ps

module stream_stage import mover_pkg::*; #(
    parameter type payload_t = logic [DATA_BITS-1:0]
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_payload,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_payload,
    input  logic     out_ready
);

    // The second entry catches an item while the output is stalled
    logic     skid_valid;
    payload_t skid_payload;
    logic     out_load;
    logic     in_accept;

    // Upstream may push whenever the skid entry is empty
    assign in_ready  = !skid_valid;
    assign in_accept = in_valid && in_ready;

    // The output register takes a new item when it is empty or being drained
    assign out_load = out_ready || !out_valid;

    always_ff @(posedge clock) begin
        if (!reset) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_load) begin
            // Skid content goes first to keep the items in order
            if (skid_valid) begin
                out_valid  <= 1'b1;
                skid_valid <= 1'b0;
            end else begin
                out_valid <= in_accept;
            end
        end else if (in_accept) begin
            skid_valid <= 1'b1;
        end
    end

    // Payload registers follow the valid flags above
    always_ff @(posedge clock) begin
        if (out_load) begin
            out_payload <= skid_valid ? skid_payload : in_payload;
        end else if (in_accept) begin
            skid_payload <= in_payload;
        end
    end

endmodule

// ==== src/channel_sequencer.sv ====
// Channel sequencer FSM that fetches or replays one word per channel,
// keeps the replay buffer and pulses done at the end of a pass
`timescale 1ns/10ps

module channel_sequencer import mover_pkg::*; (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  start,
    input  logic                  repeat_outputs,
    output logic                  done,
    input  logic [COUNT_BITS-1:0] channel_count,
    input  logic [ADDR_BITS-1:0]  source_addrs [MAX_CHANNELS],
    input  logic [ADDR_BITS-1:0]  target_addrs [MAX_CHANNELS],
    output logic                  req_valid,
    output request_t              req_payload,
    input  logic                  req_ready,
    input  logic                  response_valid,
    input  logic [DATA_BITS-1:0]  response_data,
    output logic                  response_ready,
    output logic                  emit_valid,
    output output_t               emit_payload,
    input  logic                  emit_ready
);

    sequencer_state_t        state;
    sequencer_state_t        advance_state;
    logic [CHANNEL_BITS-1:0] channel_index;
    logic [DATA_BITS-1:0]    replay_buffer [MAX_CHANNELS];
    logic                    last_channel;
    logic                    request_accept;
    logic                    response_accept;
    logic                    replay_load;
    logic                    emit_accept;

    // The index is widened to the count width so a count of 8 compares right
    assign last_channel = (COUNT_BITS'(channel_index) == channel_count - COUNT_BITS'(1));

    // Requests are offered straight from the live address registers
    assign req_valid      = (state == issue_request);
    assign req_payload    = source_addrs[channel_index];
    assign request_accept = req_valid && req_ready;

    // No new response is taken while the previous word still waits to leave
    assign response_ready  = (state == wait_response) && !emit_valid;
    assign response_accept = response_valid && response_ready;

    // In replay the buffered word is loaded once the emit register is free
    assign replay_load = (state == replay_word) && !emit_valid;
    assign emit_accept = emit_valid && emit_ready;

    // Where to go once the current word has left for the output stage
    always_comb begin
        if (last_channel) begin
            advance_state = done_pulse;
        end else if (state == replay_word) begin
            advance_state = replay_word;
        end else begin
            advance_state = issue_request;
        end
    end

    // Done is a pure state decode and lasts exactly one cycle
    assign done = (state == done_pulse);

    always_ff @(posedge clock) begin
        if (!reset) begin
            state         <= idle;
            channel_index <= '0;
            emit_valid    <= 1'b0;
            for (int i = 0; i < MAX_CHANNELS; i++) begin
                replay_buffer[i] <= '0;
            end
        end else begin
            case (state)
                idle: begin
                    channel_index <= '0;
                    // Start has priority when both commands arrive together
                    if (start) begin
                        state <= (channel_count == '0) ? done_pulse : issue_request;
                    end else if (repeat_outputs) begin
                        state <= (channel_count == '0) ? done_pulse : replay_word;
                    end
                end
                issue_request: begin
                    if (request_accept) begin
                        state <= wait_response;
                    end
                end
                wait_response: begin
                    // Each response refreshes the buffer for later replays
                    if (response_accept) begin
                        replay_buffer[channel_index] <= response_data;
                        emit_valid                   <= 1'b1;
                    end
                end
                replay_word: begin
                    if (replay_load) begin
                        emit_valid <= 1'b1;
                    end
                end
                done_pulse: begin
                    state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase

            // Moving on to the next channel waits for the output stage
            // to take the word, in both fetch and replay
            if (emit_accept) begin
                emit_valid <= 1'b0;
                state      <= advance_state;
                if (!last_channel) begin
                    channel_index <= channel_index + 1'b1;
                end
            end
        end
    end

    // Output word register, fed from the response or the replay buffer
    always_ff @(posedge clock) begin
        if (response_accept) begin
            emit_payload.data <= response_data;
            emit_payload.dest <= target_addrs[channel_index];
        end else if (replay_load) begin
            emit_payload.data <= replay_buffer[channel_index];
            emit_payload.dest <= target_addrs[channel_index];
        end
    end

endmodule

// ==== src/data_mover_top.sv ====
// Top level of the data mover with the register bank, the sequencer and
// the request and output stream stages
`timescale 1ns/10ps

module data_mover_top import mover_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    start,
    input  logic                    repeat_outputs,
    output logic                    done,
    input  logic                    wb_cyc,
    input  logic                    wb_stb,
    input  logic                    wb_we,
    input  logic [WB_ADDR_BITS-1:0] wb_adr,
    input  logic [DATA_BITS-1:0]    wb_dat_w,
    output logic [DATA_BITS-1:0]    wb_dat_r,
    output logic                    wb_ack,
    output logic                    request_valid,
    input  logic                    request_ready,
    output logic [ADDR_BITS-1:0]    request_addr,
    input  logic                    response_valid,
    output logic                    response_ready,
    input  logic [DATA_BITS-1:0]    response_data,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic [DATA_BITS-1:0]    out_data,
    output logic [ADDR_BITS-1:0]    out_dest
);

    logic [COUNT_BITS-1:0] channel_count;
    logic [ADDR_BITS-1:0]  source_addrs [MAX_CHANNELS];
    logic [ADDR_BITS-1:0]  target_addrs [MAX_CHANNELS];
    logic                  req_valid;
    logic                  req_ready;
    request_t              req_payload;
    logic                  emit_valid;
    logic                  emit_ready;
    output_t               emit_payload;
    output_t               out_word;

    wb_register_bank registers (
        .clock         (clock),
        .reset         (reset),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack),
        .channel_count (channel_count),
        .source_addrs  (source_addrs),
        .target_addrs  (target_addrs)
    );

    channel_sequencer sequencer (
        .clock          (clock),
        .reset          (reset),
        .start          (start),
        .repeat_outputs (repeat_outputs),
        .done           (done),
        .channel_count  (channel_count),
        .source_addrs   (source_addrs),
        .target_addrs   (target_addrs),
        .req_valid      (req_valid),
        .req_payload    (req_payload),
        .req_ready      (req_ready),
        .response_valid (response_valid),
        .response_data  (response_data),
        .response_ready (response_ready),
        .emit_valid     (emit_valid),
        .emit_payload   (emit_payload),
        .emit_ready     (emit_ready)
    );

    // Request path to the source memory
    stream_stage #(.payload_t(request_t)) request_stage (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (req_valid),
        .in_payload  (req_payload),
        .in_ready    (req_ready),
        .out_valid   (request_valid),
        .out_payload (request_addr),
        .out_ready   (request_ready)
    );

    // Output path, absorbs back-pressure from the consumer
    stream_stage #(.payload_t(output_t)) output_stage (
        .clock       (clock),
        .reset       (reset),
        .in_valid    (emit_valid),
        .in_payload  (emit_payload),
        .in_ready    (emit_ready),
        .out_valid   (out_valid),
        .out_payload (out_word),
        .out_ready   (out_ready)
    );

    assign out_data = out_word.data;
    assign out_dest = out_word.dest;

endmodule

// ==== test/clock_gen.sv ====
// Testbench clock and reset source with a 10 ns period
// Reset is held low for the first three clock cycles
`timescale 1ns/10ps

module clock_gen (
    output logic clock,
    output logic reset
);

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset is released on a falling edge after three rising edges
    initial begin
        reset = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        reset = 1'b1;
    end

endmodule

// ==== test/tb_data_mover.sv ====
// Testbench for the data mover with a Wishbone host, a source memory model,
// an output monitor, a table of tests applied in a loop and a watchdog
`timescale 1ns/10ps

module tb_data_mover import mover_pkg::*; ();

    localparam int          NUM_TESTS   = 7;
    localparam logic [1:0]  CMD_START   = 2'b01;
    localparam logic [1:0]  CMD_REPEAT  = 2'b10;
    localparam logic [1:0]  CMD_BOTH    = 2'b11;
    localparam logic [31:0] CHANGED_KEY = 32'h0F0F_F0F0;

    logic                    clock;
    logic                    reset;
    logic                    start;
    logic                    repeat_outputs;
    logic                    done;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [WB_ADDR_BITS-1:0] wb_adr;
    logic [DATA_BITS-1:0]    wb_dat_w;
    logic [DATA_BITS-1:0]    wb_dat_r;
    logic                    wb_ack;
    logic                    request_valid;
    logic                    request_ready;
    logic [ADDR_BITS-1:0]    request_addr;
    logic                    response_valid;
    logic                    response_ready;
    logic [DATA_BITS-1:0]    response_data;
    logic                    out_valid;
    logic                    out_ready;
    logic [DATA_BITS-1:0]    out_data;
    logic [ADDR_BITS-1:0]    out_dest;

    // Stimulus table with one entry per test
    int                   table_count [NUM_TESTS];
    logic [ADDR_BITS-1:0] table_src   [NUM_TESTS][MAX_CHANNELS];
    logic [ADDR_BITS-1:0] table_dst   [NUM_TESTS][MAX_CHANNELS];
    logic [1:0]           table_cmd   [NUM_TESTS];
    bit                   table_stall [NUM_TESTS];
    bit                   table_mem   [NUM_TESTS];

    // Expected replay buffer content which starts at zero after reset
    logic [DATA_BITS-1:0] replay_model [MAX_CHANNELS];
    logic [47:0]          got_outputs [$];
    logic [15:0]          got_requests [$];
    logic [15:0]          pending_addrs [$];
    int                   dones_seen;
    int                   response_delay;
    bit                   response_taken;
    bit                   stall_mode;
    logic [31:0]          mem_key;
    int                   errors;
    int                   tests_passed;
    int                   tests_failed;

    clock_gen clock_source (.clock(clock), .reset(reset));

    data_mover_top dut0 (.*);

    // Source memory content follows from the address and the key models a changed memory
    function automatic logic [31:0] memory_word(input logic [15:0] addr);
        return ((32'(addr) * 32'h0001_0001) ^ 32'hA5A5_A5A5) ^ mem_key;
    endfunction

    task automatic compare_value(input string name, input logic [47:0] expected,
                                 input logic [47:0] actual);
        assert (actual === expected) else begin
            $display("Error at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // One Wishbone classic cycle where the ack must come exactly one cycle later
    task automatic wb_access(input logic is_write, input logic [3:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int cycles;
        @(negedge clock);
        // The ack of the previous cycle lasts one cycle and is gone by now
        assert (!wb_ack) else begin
            $display("Error at %0t ns: wb_ack was still high when a new cycle started", $time);
            errors++;
        end
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = is_write;
        wb_adr   = adr;
        wb_dat_w = wdata;
        cycles   = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!wb_ack && cycles < 10);
        assert (wb_ack && cycles == 1) else begin
            $display("Error at %0t ns: wb_ack was not seen one cycle after the strobe", $time);
            errors++;
        end
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic finish_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            tests_passed++;
            $display("Test %s passed", name);
        end else begin
            tests_failed++;
            $display("Test %s failed with %0d errors", name, errors - errors_before);
        end
    endtask

    // Pairs are spread out from a base so every channel gets its own address
    task automatic set_entry(input int t, input int count, input logic [15:0] src_base,
                             input logic [15:0] dst_base, input logic [1:0] cmd,
                             input bit stall, input bit mem_change);
        table_count[t] = count;
        table_cmd[t]   = cmd;
        table_stall[t] = stall;
        table_mem[t]   = mem_change;
        for (int i = 0; i < MAX_CHANNELS; i++) begin
            table_src[t][i] = src_base + 16'(i * 37);
            table_dst[t][i] = dst_base + 16'(i * 4);
        end
    endtask

    task automatic register_test();
        int          errors_before;
        logic [31:0] rdata;
        logic [31:0] word;
        errors_before = errors;
        // Outputs after reset
        compare_value("done", 48'd0, 48'(done));
        compare_value("wb_ack", 48'd0, 48'(wb_ack));
        compare_value("request_valid", 48'd0, 48'(request_valid));
        compare_value("response_ready", 48'd0, 48'(response_ready));
        compare_value("out_valid", 48'd0, 48'(out_valid));
        // Every register comes out of reset as zero
        for (int a = REG_COUNT_INDEX; a <= REG_COUNT_INDEX + MAX_CHANNELS; a++) begin
            wb_access(1'b0, 4'(a), 32'd0, rdata);
            compare_value("wb_dat_r reset", 48'd0, 48'(rdata));
        end
        for (int i = 0; i < MAX_CHANNELS; i++) begin
            word = {16'hC000 + 16'(i), 16'h0500 + 16'(i * 3)};
            wb_access(1'b1, 4'(REG_COUNT_INDEX + 1 + i), word, rdata);
        end
        wb_access(1'b1, 4'(REG_COUNT_INDEX), 32'd5, rdata);
        wb_access(1'b0, 4'(REG_COUNT_INDEX), 32'd0, rdata);
        compare_value("wb_dat_r count", 48'd5, 48'(rdata));
        for (int i = 0; i < MAX_CHANNELS; i++) begin
            word = {16'hC000 + 16'(i), 16'h0500 + 16'(i * 3)};
            wb_access(1'b0, 4'(REG_COUNT_INDEX + 1 + i), 32'd0, rdata);
            compare_value("wb_dat_r channel", 48'(word), 48'(rdata));
        end
        // A count above the channel total is stored as the maximum
        wb_access(1'b1, 4'(REG_COUNT_INDEX), 32'd12, rdata);
        wb_access(1'b0, 4'(REG_COUNT_INDEX), 32'd0, rdata);
        compare_value("wb_dat_r count", 48'(MAX_CHANNELS), 48'(rdata));
        for (int a = REG_COUNT_INDEX + MAX_CHANNELS + 1; a < 16; a++) begin
            wb_access(1'b1, 4'(a), 32'hFFFF_FFFF, rdata);
            wb_access(1'b0, 4'(a), 32'd0, rdata);
            compare_value("wb_dat_r unmapped", 48'd0, 48'(rdata));
        end
        finish_test("register access", errors_before);
    endtask

    task automatic program_channels(input int t);
        logic [31:0] rdata;
        wb_access(1'b1, 4'(REG_COUNT_INDEX), 32'(table_count[t]), rdata);
        for (int i = 0; i < MAX_CHANNELS; i++) begin
            wb_access(1'b1, 4'(REG_COUNT_INDEX + 1 + i), {table_dst[t][i], table_src[t][i]},
                      rdata);
        end
    endtask

    task automatic run_test(input int t);
        logic [47:0] want_outputs [$];
        logic [15:0] want_requests [$];
        int          errors_before;
        int          cycles;
        bit          pulse_again;
        errors_before = errors;
        program_channels(t);
        mem_key = table_mem[t] ? CHANGED_KEY : 32'h0;
        // A fetch refreshes the buffer from memory while a replay only reads it
        for (int i = 0; i < table_count[t]; i++) begin
            if (table_cmd[t][0]) begin
                replay_model[i] = memory_word(table_src[t][i]);
                want_requests.push_back(table_src[t][i]);
            end
            want_outputs.push_back({replay_model[i], table_dst[t][i]});
        end
        got_outputs.delete();
        got_requests.delete();
        dones_seen  = 0;
        stall_mode  = table_stall[t];
        pulse_again = table_cmd[t][0] && table_count[t] >= 2;
        @(negedge clock);
        start          = table_cmd[t][0];
        repeat_outputs = table_cmd[t][1];
        cycles         = 0;
        do begin
            @(negedge clock);
            cycles++;
            // A second start once the pass is running must be ignored
            start = pulse_again && got_requests.size() > 0;
            if (start) begin
                pulse_again = 1'b0;
            end
            repeat_outputs = 1'b0;
        end while ((dones_seen == 0 || got_outputs.size() < want_outputs.size()) && cycles < 300);
        assert (cycles < 300) else begin
            $display("Error at %0t ns: entry %0d did not finish within 300 cycles", $time, t);
            errors++;
        end
        // Extra cycles so that a late duplicate or a second pass would show up
        repeat (10) @(negedge clock);
        stall_mode = 1'b0;
        compare_value("done pulses", 48'd1, 48'(dones_seen));
        compare_value("request count", 48'(want_requests.size()), 48'(got_requests.size()));
        compare_value("output count", 48'(want_outputs.size()), 48'(got_outputs.size()));
        foreach (want_requests[i]) begin
            if (i < got_requests.size()) begin
                compare_value("request_addr", 48'(want_requests[i]), 48'(got_requests[i]));
            end
        end
        foreach (want_outputs[i]) begin
            if (i < got_outputs.size()) begin
                compare_value("out_data", 48'(want_outputs[i][47:16]), 48'(got_outputs[i][47:16]));
                compare_value("out_dest", 48'(want_outputs[i][15:0]), 48'(got_outputs[i][15:0]));
            end
        end
        finish_test($sformatf("entry %0d", t), errors_before);
    endtask

    // Memory model and monitors where a handshake seen here completes at the next rising edge
    always @(negedge clock) begin
        if (reset) begin
            if (response_taken) begin
                response_valid = 1'b0;
                response_taken = 1'b0;
            end
            out_ready     = stall_mode ? 1'($urandom_range(1, 0)) : 1'b1;
            request_ready = stall_mode ? 1'($urandom_range(1, 0)) : 1'b1;
            if (!response_valid && pending_addrs.size() > 0) begin
                if (response_delay > 0) begin
                    response_delay--;
                end else begin
                    response_valid = 1'b1;
                    response_data  = memory_word(pending_addrs.pop_front());
                end
            end
            if (request_valid && request_ready) begin
                pending_addrs.push_back(request_addr);
                got_requests.push_back(request_addr);
                response_delay = $urandom_range(4, 0);
            end
            if (response_valid && response_ready) begin
                response_taken = 1'b1;
            end
            if (out_valid && out_ready) begin
                got_outputs.push_back({out_data, out_dest});
            end
            if (done) begin
                dones_seen++;
            end
        end
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("Timeout: the run did not finish within %0d ns", NUM_TESTS * 2000);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(47));
        start          = 1'b0;
        repeat_outputs = 1'b0;
        wb_cyc         = 1'b0;
        wb_stb         = 1'b0;
        wb_we          = 1'b0;
        wb_adr         = '0;
        wb_dat_w       = '0;
        request_ready  = 1'b1;
        response_valid = 1'b0;
        response_data  = '0;
        out_ready      = 1'b1;
        response_taken = 1'b0;
        response_delay = 0;
        stall_mode     = 1'b0;
        mem_key        = '0;
        dones_seen     = 0;
        errors         = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        for (int i = 0; i < MAX_CHANNELS; i++) begin
            replay_model[i] = '0;
        end
        // Replay right after reset, fetches with and without stalls, replay after a
        // memory change, both commands together, and an empty channel list
        set_entry(0, 3, 16'h0100, 16'h8000, CMD_REPEAT, 1'b0, 1'b0);
        set_entry(1, 4, 16'h0200, 16'h9000, CMD_START, 1'b0, 1'b0);
        set_entry(2, 8, 16'h1234, 16'hA000, CMD_START, 1'b1, 1'b0);
        set_entry(3, 8, 16'h1234, 16'hA000, CMD_REPEAT, 1'b1, 1'b1);
        set_entry(4, 5, 16'h0300, 16'hB000, CMD_BOTH, 1'b0, 1'b1);
        set_entry(5, 0, 16'h0400, 16'hB800, CMD_START, 1'b0, 1'b0);
        set_entry(6, 6, 16'h4000, 16'hC000, CMD_START, 1'b1, 1'b0);
        @(posedge reset);
        register_test();
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
src/mover_pkg.sv
src/wb_register_bank.sv
src/stream_stage.sv
src/channel_sequencer.sv
src/data_mover_top.sv
test/clock_gen.sv
test/tb_data_mover.sv

// ==== Bender.yml ====
package:
  name: data_mover

sources:
  - src/mover_pkg.sv
  - src/wb_register_bank.sv
  - src/stream_stage.sv
  - src/channel_sequencer.sv
  - src/data_mover_top.sv
  - target: test
    files:
      - test/clock_gen.sv
      - test/tb_data_mover.sv
